// File: Bender.yml
package:
  name: dmem_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/dmem_pkg.sv
      - hw/access_ctrl.sv
      - hw/byte_ram.sv
      - hw/mmio_regs.sv
      - hw/load_formatter.sv
      - hw/dmem_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_dmem.sv

// File: dv/tb_dmem.sv
`timescale 1ns/1ps
`include "dmem_settings.svh"

module tb_dmem import dmem_pkg::*;
();

    localparam int N_FILL      = 32;
    localparam int N_RAND      = 300;
    localparam int N_TOTAL     = N_FILL + N_RAND + 3 + 2;
    localparam int CYCLE_LIMIT = 4 * N_TOTAL + 200;

    logic clk, rst, trigger;
    logic req_valid, req_ready, req_write;
    logic [2:0] req_mode;
    logic [31:0] req_addr, req_wdata;
    logic rsp_valid, rsp_ready, rsp_err;
    logic [31:0] rsp_rdata;
    logic [`GPIO_BITS-1:0] gpio_out;

    logic [7:0] ram_model [0:(1 << `RAM_ADDR_BITS)-1];
    logic m_flag;
    logic [`GPIO_BITS-1:0] m_gpio;
    mem_word_u exp_data_q[$];
    bit exp_err_q[$];
    logic [31:0] seed_req, seed_bp;
    bit bp_on, held, acc_prev, held_err;
    mem_word_u held_data;
    int cycles, n_mis, n_fail, n_acc, n_rsp;

    dmem_top dut (.*);

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] size_of(input logic [2:0] mode);
        case (mode)
            `MODE_WORD:              return 32'd4;
            `MODE_HALF, `MODE_HALFU: return 32'd2;
            `MODE_BYTE, `MODE_BYTEU: return 32'd1;
            default:                 return 32'd0;
        endcase
    endfunction

    task automatic check_word(input string name, input mem_word_u got, input mem_word_u exp);
        if (got.w !== exp.w)
        begin
            n_mis++;
            $display("mismatch %s: got %h, expected %h", name, got.w, exp.w);
        end
    endtask

    task automatic check_err(input string name, input bit got, input bit exp);
        if (got !== exp)
        begin
            n_mis++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_gpio(input string name, input logic [`GPIO_BITS-1:0] got,
                              input logic [`GPIO_BITS-1:0] exp);
        if (got !== exp)
        begin
            n_mis++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic protocol_error(input string what);
        n_fail++;
        $display("error at cycle %0d: %s", cycles, what);
    endtask

    // model of one accepted access, in acceptance order
    task automatic predict(input logic wr, input logic [2:0] mode, input logic [31:0] addr,
                           input logic [31:0] data);
        logic [31:0] sz;
        logic [31:0] regw;
        mem_word_u val;
        logic err;
        int i;
        sz = size_of(mode);
        err = (sz == 0) || ((addr & (sz - 1)) != 0);
        val.w = '0;
        regw = '0;
        n_acc++;
        if (!err && (addr >> `MMIO_OFS_BITS) == (`MMIO_BASE >> `MMIO_OFS_BITS))
        begin
            if (wr && addr[3:0] == `MMIO_GPIO_OFS)
                m_gpio = data[`GPIO_BITS-1:0];
            if (!wr && addr[3:0] == `MMIO_GPIO_OFS)
                regw = 32'(m_gpio);
            if (!wr && addr[3:0] == `MMIO_TRIG_OFS)
            begin
                regw = {31'b0, m_flag};
                m_flag = 1'b0; // clear on read
            end
            for (i = 0; i < sz; i++)
                val.b[i] = regw[8 * (addr[1:0] + i) +: 8];
        end
        else if (!err)
        begin
            for (i = 0; i < sz; i++)
            begin
                if (wr)
                    ram_model[(addr + i) % (1 << `RAM_ADDR_BITS)] = data[8 * i +: 8];
                else
                    val.b[i] = ram_model[(addr + i) % (1 << `RAM_ADDR_BITS)];
            end
        end
        if (mode == `MODE_HALF)
            val.w = {{16{val.w[15]}}, val.w[15:0]};
        if (mode == `MODE_BYTE)
            val.w = {{24{val.w[7]}}, val.w[7:0]};
        exp_data_q.push_back(val);
        exp_err_q.push_back(err);
    endtask

    task automatic send(input logic wr, input logic [2:0] mode, input logic [31:0] addr,
                        input logic [31:0] data);
        if (bp_on)
        begin
            seed_req = lcg(seed_req);
            if (seed_req[29:28] == 2'b00)
            begin
                @(posedge clk); // idle gap
                #2;
            end
        end
        req_valid = 1'b1;
        req_write = wr;
        req_mode = mode;
        req_addr = addr;
        req_wdata = data;
        @(negedge clk);
        while (!req_ready)
            @(negedge clk);
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic random_access();
        logic [31:0] r;
        logic [31:0] data;
        logic [2:0] mode;
        logic [31:0] addr;
        seed_req = lcg(seed_req);
        r = {seed_req[15:0], seed_req[31:16]};
        seed_req = lcg(seed_req);
        data = seed_req;
        mode = 3'd1 + 3'(r[6:4] % 5);
        addr = 32'h200 | {25'b0, r[14:8]};
        if (r[15])
            addr = addr + {17'b0, r[18:16], 12'h000}; // aliases through wrap
        if (r[3:0] == 4'd2 || r[3:0] == 4'd3)
            addr = `MMIO_BASE | {28'b0, r[11:8]};
        if (r[3:0] == 4'd1 && size_of(mode) == 1)
            mode = `MODE_WORD;
        if (size_of(mode) != 0)
            addr = addr & ~(size_of(mode) - 1);
        if (r[3:0] == 4'd1)
            addr = addr | 32'h1;
        if (r[3:0] == 4'd0)
            mode = r[20] ? 3'd0 : (r[21] ? 3'd6 : 3'd7);
        send(r[7], mode, addr, data);
    endtask

    task automatic drain();
        while (exp_data_q.size() != 0)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: run passed the limit of %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        #2;
        seed_bp = lcg(seed_bp);
        rsp_ready = !bp_on || (seed_bp[30:29] != 2'b00);
    end

    // sampled mid-cycle, everything settled
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_gpio("gpio_out", gpio_out, m_gpio);
            if (held)
            begin
                if (!rsp_valid)
                    protocol_error("rsp_valid dropped before rsp_ready");
                check_word("rsp_rdata (held)", rsp_rdata, held_data);
                check_err("rsp_err (held)", rsp_err, held_err);
            end
            if (acc_prev && !rsp_valid)
                protocol_error("no response one cycle after acceptance");
            if (req_ready != (!rsp_valid || rsp_ready))
                protocol_error("req_ready does not follow the response slot");
            if (rsp_valid && rsp_ready)
            begin
                if (exp_data_q.size() == 0)
                    protocol_error("response without an outstanding request");
                else
                begin
                    check_word("rsp_rdata", rsp_rdata, exp_data_q.pop_front());
                    check_err("rsp_err", rsp_err, exp_err_q.pop_front());
                    n_rsp++;
                end
            end
            held = rsp_valid && !rsp_ready;
            held_data.w = rsp_rdata;
            held_err = rsp_err;
            acc_prev = req_valid && req_ready;
            if (acc_prev)
                predict(req_write, req_mode, req_addr, req_wdata);
        end
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        trigger = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_mode = 3'd0;
        req_addr = '0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        m_flag = 1'b0;
        m_gpio = '0;
        seed_req = 32'h1059;
        seed_bp = lcg(32'h1059);
        bp_on = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        if (rsp_valid)
            protocol_error("rsp_valid high after reset");

        // fill the test region, back to back
        for (int i = 0; i < N_FILL; i++)
        begin
            seed_req = lcg(seed_req);
            send(1'b1, `MODE_WORD, 32'h200 + 4 * i, seed_req);
        end

        bp_on = 1'b1;
        for (int i = 0; i < N_RAND; i++)
            random_access();

        send(1'b1, `MODE_WORD, `MMIO_BASE + `MMIO_GPIO_OFS, 32'hA5C3_1E96);
        send(1'b0, `MODE_WORD, `MMIO_BASE + `MMIO_GPIO_OFS, 32'h0);
        send(1'b0, `MODE_WORD, `MMIO_BASE + 32'h8, 32'h0);

        // trigger pulse while idle
        drain();
        repeat (2) @(posedge clk);
        #2;
        trigger = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        trigger = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        m_flag = 1'b1;
        send(1'b0, `MODE_WORD, `MMIO_BASE + `MMIO_TRIG_OFS, 32'h0);
        send(1'b0, `MODE_WORD, `MMIO_BASE + `MMIO_TRIG_OFS, 32'h0);

        drain();
        repeat (3) @(posedge clk);
        if (n_acc != N_TOTAL || n_rsp != n_acc)
            protocol_error($sformatf("%0d requests accepted, %0d responses, %0d sent",
                                     n_acc, n_rsp, N_TOTAL));
        $display("errors: %0d mismatches, %0d other failures", n_mis, n_fail);
        if (n_mis + n_fail == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: hw/access_ctrl.sv
`timescale 1ns/1ps
`include "dmem_settings.svh"

module access_ctrl import dmem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  logic                      req_write,
    input  logic [2:0]                req_mode,
    input  logic [31:0]               req_addr,
    input  logic [31:0]               req_wdata,
    input  logic                      slot_free,
    output logic                      req_ready,
    output logic                      issue,
    output logic                      tag_mmio,
    output logic [1:0]                tag_ofs,
    output logic [2:0]                tag_mode,
    output logic                      tag_err,
    output logic                      tag_write,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [`RAM_ADDR_BITS-3:0] ram_idx,
    output logic [3:0]                ram_be,
    output mem_word_u                 ram_wdata,
    output logic                      mmio_en,
    output logic                      mmio_we,
    output logic [3:0]                mmio_ofs,
    output logic [31:0]               mmio_wdata
);

    localparam logic [31:0] MMIO_BASE_W = `MMIO_BASE;

    logic accept;
    logic mode_ok;
    logic misaligned;
    logic err;
    logic in_window;

    assign req_ready = slot_free;
    assign accept    = req_valid && slot_free;

    always_comb
    begin
        mode_ok    = 1'b1;
        misaligned = 1'b0;
        case (req_mode)
            `MODE_WORD:               misaligned = |req_addr[1:0];
            `MODE_HALF, `MODE_HALFU:  misaligned = req_addr[0];
            `MODE_BYTE, `MODE_BYTEU:  misaligned = 1'b0;
            default:                  mode_ok    = 1'b0;
        endcase
    end

    assign err       = !mode_ok || misaligned;
    assign in_window = req_addr[31:`MMIO_OFS_BITS] == MMIO_BASE_W[31:`MMIO_OFS_BITS];

    // byte enables and lane replication for stores
    always_comb
    begin
        ram_be = 4'b0000;
        ram_wdata.w = req_wdata;
        case (req_mode)
            `MODE_WORD:
            begin
                ram_be = 4'b1111;
            end
            `MODE_HALF, `MODE_HALFU:
            begin
                ram_be = 4'b0011 << req_addr[1:0];
                ram_wdata.b[0] = req_wdata[7:0];
                ram_wdata.b[1] = req_wdata[15:8];
                ram_wdata.b[2] = req_wdata[7:0];
                ram_wdata.b[3] = req_wdata[15:8];
            end
            `MODE_BYTE, `MODE_BYTEU:
            begin
                ram_be = 4'b0001 << req_addr[1:0];
                for (int i = 0; i < 4; i++)
                    ram_wdata.b[i] = req_wdata[7:0];
            end
            default:
            begin
                ram_be = 4'b0000; // never reaches the RAM
            end
        endcase
    end

    assign ram_en     = accept && !err && !in_window;
    assign ram_we     = req_write;
    assign ram_idx    = req_addr[`RAM_ADDR_BITS-1:2];

    assign mmio_en    = accept && !err && in_window;
    assign mmio_we    = req_write;
    assign mmio_ofs   = req_addr[3:0];
    assign mmio_wdata = req_wdata;

    assign issue      = accept;
    assign tag_mmio   = in_window;
    assign tag_ofs    = req_addr[1:0];
    assign tag_mode   = req_mode;
    assign tag_err    = err;
    assign tag_write  = req_write;

    // stalled request holds still until taken
    assert property (@(posedge clk) disable iff (rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req_write) && $stable(req_mode)
                                       && $stable(req_addr) && $stable(req_wdata)));

endmodule

// File: hw/byte_ram.sv
`timescale 1ns/1ps
`include "dmem_settings.svh"

module byte_ram import dmem_pkg::*;
(
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [`RAM_ADDR_BITS-3:0] idx,
    input  logic [3:0]                be,
    input  mem_word_u                 wdata,
    output mem_word_u                 rdata
);

    localparam int RAM_WORDS = 1 << (`RAM_ADDR_BITS - 2);

    mem_word_u mem [0:RAM_WORDS-1];

    // write enabled lanes only
    always_ff @(posedge clk)
    begin
        if (en && we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (be[i])
                    mem[idx].b[i] <= wdata.b[i];
            end
        end
    end

    // read register holds until the next read
    always_ff @(posedge clk)
    begin
        if (en && !we)
            rdata <= mem[idx];
    end

    assert property (@(posedge clk) (en && we) |-> (be != 4'b0000));

endmodule

// File: hw/dmem_pkg.sv
package dmem_pkg;

    // one memory word, seen whole or as four little-endian byte lanes;
    // b[0] is the byte at offset 0
    typedef union packed {
        logic [31:0]       w;
        logic [3:0][7:0]   b;
    } mem_word_u;

endpackage

// File: hw/dmem_top.sv
`timescale 1ns/1ps
`include "dmem_settings.svh"

module dmem_top import dmem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [2:0]            req_mode,
    input  logic [31:0]           req_addr,
    input  logic [31:0]           req_wdata,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [31:0]           rsp_rdata,
    output logic                  rsp_err,
    input  logic                  trigger,
    output logic [`GPIO_BITS-1:0] gpio_out
);

    logic                      slot_free;
    logic                      issue;
    logic                      tag_mmio;
    logic [1:0]                tag_ofs;
    logic [2:0]                tag_mode;
    logic                      tag_err;
    logic                      tag_write;
    logic                      ram_en;
    logic                      ram_we;
    logic [`RAM_ADDR_BITS-3:0] ram_idx;
    logic [3:0]                ram_be;
    mem_word_u                 ram_wdata;
    mem_word_u                 ram_rdata;
    logic                      mmio_en;
    logic                      mmio_we;
    logic [3:0]                mmio_ofs;
    logic [31:0]               mmio_wdata;
    logic [31:0]               mmio_rdata;

    access_ctrl u_access_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_mode   (req_mode),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .slot_free  (slot_free),
        .req_ready  (req_ready),
        .issue      (issue),
        .tag_mmio   (tag_mmio),
        .tag_ofs    (tag_ofs),
        .tag_mode   (tag_mode),
        .tag_err    (tag_err),
        .tag_write  (tag_write),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_idx    (ram_idx),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .mmio_en    (mmio_en),
        .mmio_we    (mmio_we),
        .mmio_ofs   (mmio_ofs),
        .mmio_wdata (mmio_wdata)
    );

    byte_ram u_byte_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .idx   (ram_idx),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mmio_regs u_mmio_regs (
        .clk      (clk),
        .rst      (rst),
        .en       (mmio_en),
        .we       (mmio_we),
        .ofs      (mmio_ofs),
        .wdata    (mmio_wdata),
        .trigger  (trigger),
        .rdata    (mmio_rdata),
        .gpio_out (gpio_out)
    );

    load_formatter u_load_formatter (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .tag_mmio   (tag_mmio),
        .tag_ofs    (tag_ofs),
        .tag_mode   (tag_mode),
        .tag_err    (tag_err),
        .tag_write  (tag_write),
        .ram_rdata  (ram_rdata),
        .mmio_rdata (mmio_rdata),
        .rsp_ready  (rsp_ready),
        .slot_free  (slot_free),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err)
    );

endmodule

// File: hw/load_formatter.sv
`timescale 1ns/1ps
`include "dmem_settings.svh"

module load_formatter import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue,
    input  logic        tag_mmio,
    input  logic [1:0]  tag_ofs,
    input  logic [2:0]  tag_mode,
    input  logic        tag_err,
    input  logic        tag_write,
    input  mem_word_u   ram_rdata,
    input  logic [31:0] mmio_rdata,
    input  logic        rsp_ready,
    output logic        slot_free,
    output logic        rsp_valid,
    output logic [31:0] rsp_rdata,
    output logic        rsp_err
);

    logic       valid_q;
    logic       mmio_q;
    logic [1:0] ofs_q;
    logic [2:0] mode_q;
    logic       err_q;
    logic       write_q;

    mem_word_u   src;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign slot_free = !valid_q || rsp_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_q <= 1'b0;
        else if (issue)
            valid_q <= 1'b1;
        else if (rsp_ready)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            mmio_q  <= tag_mmio;
            ofs_q   <= tag_ofs;
            mode_q  <= tag_mode;
            err_q   <= tag_err;
            write_q <= tag_write;
        end
    end

    always_comb
    begin
        src.w  = mmio_q ? mmio_rdata : ram_rdata.w;
        lane_b = src.b[ofs_q];
        lane_h = {src.b[{ofs_q[1], 1'b1}], src.b[{ofs_q[1], 1'b0}]};
        case (mode_q)
            `MODE_WORD:  rsp_rdata = src.w;
            `MODE_HALF:  rsp_rdata = {{16{lane_h[15]}}, lane_h};
            `MODE_BYTE:  rsp_rdata = {{24{lane_b[7]}}, lane_b};
            `MODE_HALFU: rsp_rdata = {16'b0, lane_h};
            `MODE_BYTEU: rsp_rdata = {24'b0, lane_b};
            default:     rsp_rdata = '0;
        endcase
        if (err_q || write_q)
            rsp_rdata = '0;        // stores and errors return zero
    end

    assign rsp_valid = valid_q;
    assign rsp_err   = err_q;

    // held response must not move until taken
    assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)));

endmodule

// File: hw/mmio_regs.sv
`timescale 1ns/1ps
`include "dmem_settings.svh"

module mmio_regs
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  we,
    input  logic [3:0]            ofs,
    input  logic [31:0]           wdata,
    input  logic                  trigger,
    output logic [31:0]           rdata,
    output logic [`GPIO_BITS-1:0] gpio_out
);

    logic trig_meta;
    logic trig_sync;
    logic trig_flag;
    logic trig_read;
    logic gpio_write;

    assign trig_read  = en && !we && (ofs == `MMIO_TRIG_OFS);
    assign gpio_write = en && we && (ofs == `MMIO_GPIO_OFS);

    // two-flop synchronizer
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            trig_meta <= 1'b0;
            trig_sync <= 1'b0;
        end
        else
        begin
            trig_meta <= trigger;
            trig_sync <= trig_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            trig_flag <= 1'b0;
        else if (trig_sync)
            trig_flag <= 1'b1;     // set beats clear
        else if (trig_read)
            trig_flag <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            gpio_out <= '0;
        else if (gpio_write)
            gpio_out <= wdata[`GPIO_BITS-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (en && !we)
        begin
            case (ofs)
                `MMIO_TRIG_OFS: rdata <= {31'b0, trig_flag};
                `MMIO_GPIO_OFS: rdata <= {{(32-`GPIO_BITS){1'b0}}, gpio_out};
                default:        rdata <= '0;
            endcase
        end
    end

endmodule

// File: include/dmem_settings.svh
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// access mode codes, as the core encodes them
`define MODE_WORD      3'd1
`define MODE_HALF      3'd2
`define MODE_BYTE      3'd3
`define MODE_HALFU     3'd4
`define MODE_BYTEU     3'd5

`define RAM_ADDR_BITS  12           // 4 KiB, wraps
`define MMIO_BASE      32'h0000_0100
`define MMIO_OFS_BITS  4            // 16 byte window
`define MMIO_TRIG_OFS  4'h0
`define MMIO_GPIO_OFS  4'h4

`define GPIO_BITS      8

`endif

// File: tb.f
+incdir+include
hw/dmem_pkg.sv
hw/access_ctrl.sv
hw/byte_ram.sv
hw/mmio_regs.sv
hw/load_formatter.sv
hw/dmem_top.sv
dv/tb_dmem.sv
